// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tbCpuTop \
    -f rvMulticycle.f -o simv

if ./obj_dir/simv | tee /dev/stderr | grep "Result: PASSED" > /dev/null; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// File: rvMulticycle.f
source/rvPkg.sv
source/aluUnit.sv
source/immediateGen.sv
source/registerFile.sv
source/datapathRegs.sv
source/controlFsm.sv
source/cpuTop.sv
testbench/cpuTop_properties.sv
testbench/tbCpuTop.sv

// File: source/aluUnit.sv
// ALU and branch comparator
`timescale 1ns/1ps

module aluUnit (
    input  rvPkg::wordT  opA,
    input  rvPkg::wordT  opB,
    input  rvPkg::aluOpT aluOp,
    input  logic [2:0]   funct3,
    output rvPkg::wordT  aluResult,
    output logic         takeBranch
);
    import rvPkg::*;

    logic [4:0] shamt;
    logic       isEq;
    logic       isLt;
    logic       isLtu;

    assign shamt = opB[4:0];
    assign isEq  = (opA == opB);
    assign isLt  = ($signed(opA) < $signed(opB));
    assign isLtu = (opA < opB);

    always_comb begin
        case (aluOp)
            aluAdd:   aluResult = opA + opB;
            aluSub:   aluResult = opA - opB;
            aluSll:   aluResult = opA << shamt;
            aluSlt:   aluResult = {31'b0, isLt};
            aluSltu:  aluResult = {31'b0, isLtu};
            aluXor:   aluResult = opA ^ opB;
            aluSrl:   aluResult = opA >> shamt;
            aluSra:   aluResult = wordT'($signed(opA) >>> shamt);
            aluOr:    aluResult = opA | opB;
            aluAnd:   aluResult = opA & opB;
            aluPassB: aluResult = opB;
            default:  aluResult = '0;
        endcase
    end

    // evaluated on the rs1/rs2 latches during branchResolve
    always_comb begin
        case (funct3)
            3'b000:  takeBranch = isEq;
            3'b001:  takeBranch = !isEq;
            3'b100:  takeBranch = isLt;
            3'b101:  takeBranch = !isLt;
            3'b110:  takeBranch = isLtu;
            3'b111:  takeBranch = !isLtu;
            default: takeBranch = 1'b0;
        endcase
    end

endmodule

// File: source/controlFsm.sv
// Multicycle controller
`timescale 1ns/1ps

module controlFsm (
    input  logic          clk,
    input  logic          rstN,
    input  rvPkg::opcodeT opcode,
    input  logic [2:0]    funct3,
    input  logic          funct7b5,
    input  logic          takeBranch,
    output logic          memRead,
    output logic          memWrite,
    output logic          pcWrite,
    output logic          irWrite,
    output logic          mdrWrite,
    output logic          operandWrite,
    output logic          aluOutWrite,
    output logic          regWrite,
    output logic          useAluOut,
    output rvPkg::aSelT   aSel,
    output rvPkg::bSelT   bSel,
    output rvPkg::wbSelT  wbSel,
    output logic          nextPcFromAluOut,
    output rvPkg::aluOpT  aluOp,
    output logic          halted
);
    import rvPkg::*;

    cpuStateT state;
    cpuStateT nextState;
    logic     runQ;     // first edge after reset seen
    aluOpT    functOp;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= stFetch;
            runQ  <= 1'b0;
        end else begin
            state <= nextState;
            runQ  <= 1'b1;
        end
    end

    // OP and OP-IMM operation; bit 30 only picks sub for register ops
    always_comb begin
        case (funct3)
            3'b000:  functOp = (opcode == opReg && funct7b5) ? aluSub : aluAdd;
            3'b001:  functOp = aluSll;
            3'b010:  functOp = aluSlt;
            3'b011:  functOp = aluSltu;
            3'b100:  functOp = aluXor;
            3'b101:  functOp = funct7b5 ? aluSra : aluSrl;
            3'b110:  functOp = aluOr;
            default: functOp = aluAnd;
        endcase
    end

    always_comb begin
        nextState        = state;
        memRead          = 1'b0;
        memWrite         = 1'b0;
        pcWrite          = 1'b0;
        irWrite          = 1'b0;
        mdrWrite         = 1'b0;
        operandWrite     = 1'b0;
        aluOutWrite      = 1'b0;
        regWrite         = 1'b0;
        useAluOut        = 1'b0;
        nextPcFromAluOut = 1'b0;
        aSel             = aRs1;
        bSel             = bImm;
        wbSel            = wbAluOut;
        aluOp            = aluAdd;
        case (state)
            stFetch: begin
                if (runQ) begin
                    memRead   = 1'b1;
                    pcWrite   = 1'b1;   // pc + 4
                    aSel      = aPc;
                    bSel      = bFour;
                    nextState = stDecode;
                end
            end
            stDecode: begin
                irWrite      = 1'b1;
                operandWrite = 1'b1;
                aluOutWrite  = 1'b1;    // branch target
                aSel         = aOldPc;
                case (opcode)
                    opBranch: nextState = stBranchResolve;
                    opLui, opAuipc, opJal, opJalr, opImm, opReg, opLoad, opStore:
                        nextState = stExecute;
                    default: nextState = stHalt;    // ecall and anything unknown
                endcase
            end
            stExecute: begin
                aluOutWrite = 1'b1;
                nextState   = (opcode == opLoad || opcode == opStore) ? stMemAccess
                                                                      : stWriteBack;
                case (opcode)
                    opReg: begin
                        bSel  = bRs2;
                        aluOp = functOp;
                    end
                    opImm:   aluOp = functOp;
                    opLui:   aluOp = aluPassB;
                    opAuipc: aSel = aOldPc;
                    opJal, opJalr: begin
                        aSel = aOldPc;  // link value
                        bSel = bFour;
                    end
                    default: ;          // load/store address rs1 + imm
                endcase
            end
            stMemAccess: begin
                useAluOut = 1'b1;
                if (opcode == opStore) begin
                    memWrite  = 1'b1;
                    nextState = stFetch;
                end else begin
                    memRead   = 1'b1;
                    nextState = stWriteBack;
                end
            end
            stWriteBack: begin
                regWrite  = 1'b1;
                nextState = stFetch;
                if (opcode == opLoad) begin
                    wbSel    = wbMem;
                    mdrWrite = 1'b1;
                end
                if (opcode == opJal || opcode == opJalr) begin
                    pcWrite = 1'b1;     // jump target alongside the link write
                    aSel    = (opcode == opJal) ? aOldPc : aRs1;
                end
            end
            stBranchResolve: begin
                aSel             = aRs1;
                bSel             = bRs2;
                aluOp            = aluSub;
                pcWrite          = takeBranch;
                nextPcFromAluOut = 1'b1;
                nextState        = stFetch;
            end
            default: nextState = stHalt;
        endcase
    end

    assign halted = (state == stHalt);

endmodule

// File: source/cpuTop.sv
// Multicycle RV32I core
`timescale 1ns/1ps

module cpuTop #(
    parameter rvPkg::wordT resetPc = '0
) (
    input  logic        clk,
    input  logic        rstN,
    output rvPkg::wordT memAddr,
    output logic        memRead,
    output logic        memWrite,
    output rvPkg::wordT memWdata,
    input  rvPkg::wordT memRdata,
    output logic        halted
);
    import rvPkg::*;

    wordT    instr;
    wordT    rs1Data;
    wordT    rs2Data;
    wordT    imm;
    wordT    opA;
    wordT    opB;
    wordT    aluResult;
    wordT    wbData;
    regAddrT rs1Addr;
    regAddrT rs2Addr;
    regAddrT rdAddr;

    logic    pcWrite;
    logic    irWrite;
    logic    mdrWrite;
    logic    operandWrite;
    logic    aluOutWrite;
    logic    regWrite;
    logic    useAluOut;
    logic    nextPcFromAluOut;
    logic    takeBranch;
    aSelT    aSel;
    bSelT    bSel;
    wbSelT   wbSel;
    aluOpT   aluOp;

    controlFsm uControl (
        .clk(clk), .rstN(rstN),
        .opcode(instr[6:0]), .funct3(instr[14:12]), .funct7b5(instr[30]),
        .takeBranch(takeBranch),
        .memRead(memRead), .memWrite(memWrite),
        .pcWrite(pcWrite), .irWrite(irWrite), .mdrWrite(mdrWrite),
        .operandWrite(operandWrite), .aluOutWrite(aluOutWrite), .regWrite(regWrite),
        .useAluOut(useAluOut), .aSel(aSel), .bSel(bSel), .wbSel(wbSel),
        .nextPcFromAluOut(nextPcFromAluOut), .aluOp(aluOp), .halted(halted)
    );

    datapathRegs #(.resetPc(resetPc)) uDatapath (
        .clk(clk), .rstN(rstN),
        .pcWrite(pcWrite), .irWrite(irWrite), .mdrWrite(mdrWrite),
        .operandWrite(operandWrite), .aluOutWrite(aluOutWrite),
        .useAluOut(useAluOut), .aSel(aSel), .bSel(bSel), .wbSel(wbSel),
        .nextPcFromAluOut(nextPcFromAluOut),
        .memRdata(memRdata), .memAddr(memAddr), .memWdata(memWdata),
        .rs1Data(rs1Data), .rs2Data(rs2Data), .imm(imm), .aluResult(aluResult),
        .rs1Addr(rs1Addr), .rs2Addr(rs2Addr), .rdAddr(rdAddr),
        .instr(instr), .opA(opA), .opB(opB), .wbData(wbData)
    );

    registerFile uRegFile (
        .clk(clk), .rstN(rstN),
        .rs1Addr(rs1Addr), .rs2Addr(rs2Addr), .rdAddr(rdAddr),
        .wbData(wbData), .regWrite(regWrite),
        .rs1Data(rs1Data), .rs2Data(rs2Data)
    );

    immediateGen uImmGen (
        .instr(instr),
        .imm(imm)
    );

    aluUnit uAlu (
        .opA(opA), .opB(opB), .aluOp(aluOp), .funct3(instr[14:12]),
        .aluResult(aluResult), .takeBranch(takeBranch)
    );

endmodule

// File: source/datapathRegs.sv
// Datapath registers and muxes
`timescale 1ns/1ps

module datapathRegs #(
    parameter rvPkg::wordT resetPc = '0
) (
    input  logic           clk,
    input  logic           rstN,
    input  logic           pcWrite,
    input  logic           irWrite,
    input  logic           mdrWrite,
    input  logic           operandWrite,
    input  logic           aluOutWrite,
    input  logic           useAluOut,
    input  rvPkg::aSelT    aSel,
    input  rvPkg::bSelT    bSel,
    input  rvPkg::wbSelT   wbSel,
    input  logic           nextPcFromAluOut,
    input  rvPkg::wordT    memRdata,
    output rvPkg::wordT    memAddr,
    output rvPkg::wordT    memWdata,
    input  rvPkg::wordT    rs1Data,
    input  rvPkg::wordT    rs2Data,
    input  rvPkg::wordT    imm,
    input  rvPkg::wordT    aluResult,
    output rvPkg::regAddrT rs1Addr,
    output rvPkg::regAddrT rs2Addr,
    output rvPkg::regAddrT rdAddr,
    output rvPkg::wordT    instr,
    output rvPkg::wordT    opA,
    output rvPkg::wordT    opB,
    output rvPkg::wordT    wbData
);
    import rvPkg::*;

    wordT pc;
    wordT oldPc;
    wordT ir;
    wordT mdr;
    wordT aReg;
    wordT bReg;
    wordT aluOut;
    wordT mdrView;
    wordT nextPc;

    // read data arrives the cycle after the strobe, so pass it through while latching
    assign instr   = irWrite ? memRdata : ir;
    assign mdrView = mdrWrite ? memRdata : mdr;

    assign rs1Addr  = instr[19:15];
    assign rs2Addr  = instr[24:20];
    assign rdAddr   = instr[11:7];
    assign memAddr  = useAluOut ? aluOut : pc;
    assign memWdata = bReg;
    assign wbData   = (wbSel == wbMem) ? mdrView : aluOut;
    assign nextPc   = nextPcFromAluOut ? aluOut : aluResult;

    always_comb begin
        case (aSel)
            aPc:     opA = pc;
            aOldPc:  opA = oldPc;
            default: opA = aReg;
        endcase
        case (bSel)
            bRs2:    opB = bReg;
            bFour:   opB = 32'd4;
            default: opB = imm;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= resetPc;
        end else if (pcWrite) begin
            pc <= {nextPc[31:1], 1'b0};     // jalr target bit 0 cleared
        end
    end

    always_ff @(posedge clk) begin
        if (pcWrite && aSel == aPc) oldPc <= pc;   // only fetch advances from pc
        if (irWrite) ir <= memRdata;
        if (mdrWrite) mdr <= memRdata;
        if (operandWrite) begin
            aReg <= rs1Data;
            bReg <= rs2Data;
        end
        if (aluOutWrite) aluOut <= aluResult;
    end

endmodule

// File: source/immediateGen.sv
// Immediate decoder
`timescale 1ns/1ps

module immediateGen (
    input  rvPkg::wordT instr,
    output rvPkg::wordT imm
);
    import rvPkg::*;

    opcodeT opcode;

    assign opcode = instr[6:0];

    always_comb begin
        case (opcode)
            opStore: begin
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            opBranch: begin
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                       instr[11:8], 1'b0};
            end
            opLui, opAuipc: begin
                imm = {instr[31:12], 12'b0};
            end
            opJal: begin
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                       instr[30:21], 1'b0};
            end
            default: begin
                imm = {{20{instr[31]}}, instr[31:20]};  // I type
            end
        endcase
    end

endmodule

// File: source/registerFile.sv
// Integer register file
`timescale 1ns/1ps

module registerFile (
    input  logic           clk,
    input  logic           rstN,
    input  rvPkg::regAddrT rs1Addr,
    input  rvPkg::regAddrT rs2Addr,
    input  rvPkg::regAddrT rdAddr,
    input  rvPkg::wordT    wbData,
    input  logic           regWrite,
    output rvPkg::wordT    rs1Data,
    output rvPkg::wordT    rs2Data
);
    import rvPkg::*;

    wordT regs [32];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (regWrite && rdAddr != '0) begin
            regs[rdAddr] <= wbData;     // x0 writes dropped
        end
    end

    assign rs1Data = (rs1Addr == '0) ? '0 : regs[rs1Addr];
    assign rs2Data = (rs2Addr == '0) ? '0 : regs[rs2Addr];

endmodule

// File: source/rvPkg.sv
// RV32I core definitions
package rvPkg;

    typedef logic [31:0] wordT;
    typedef logic [4:0]  regAddrT;
    typedef logic [6:0]  opcodeT;

    // major opcodes, instr[6:0]
    localparam opcodeT opLui    = 7'b0110111;
    localparam opcodeT opAuipc  = 7'b0010111;
    localparam opcodeT opJal    = 7'b1101111;
    localparam opcodeT opJalr   = 7'b1100111;
    localparam opcodeT opBranch = 7'b1100011;
    localparam opcodeT opLoad   = 7'b0000011;
    localparam opcodeT opStore  = 7'b0100011;
    localparam opcodeT opImm    = 7'b0010011;
    localparam opcodeT opReg    = 7'b0110011;
    localparam opcodeT opSystem = 7'b1110011;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluSll,
        aluSlt,
        aluSltu,
        aluXor,
        aluSrl,
        aluSra,
        aluOr,
        aluAnd,
        aluPassB
    } aluOpT;

    typedef enum logic [1:0] {aPc, aOldPc, aRs1} aSelT;
    typedef enum logic [1:0] {bRs2, bFour, bImm} bSelT;
    typedef enum logic {wbAluOut, wbMem} wbSelT;

    typedef enum logic [2:0] {
        stFetch,
        stDecode,
        stExecute,
        stMemAccess,
        stWriteBack,
        stBranchResolve,
        stHalt
    } cpuStateT;

endpackage

// File: testbench/cpuTop_properties.sv
// Core port assertions
`timescale 1ns/1ps

module cpuTopProperties (
    input logic clk,
    input logic rstN,
    input logic memRead,
    input logic memWrite,
    input logic halted
);

    strobeExclusive: assert property (@(posedge clk) disable iff (!rstN)
        !(memRead && memWrite))
        else $error("memRead and memWrite are high in the same cycle");

    // async reset forces the controller idle from the first edge on
    quietInReset: assert property (@(posedge clk)
        !rstN |=> !memRead && !memWrite && !halted)
        else $error("memory strobe or halted is active during reset");

    haltSticky: assert property (@(posedge clk) disable iff (!rstN)
        halted |=> halted)
        else $error("halted dropped without a reset");

endmodule

bind cpuTop cpuTopProperties uProps (
    .clk(clk),
    .rstN(rstN),
    .memRead(memRead),
    .memWrite(memWrite),
    .halted(halted)
);

// File: testbench/tbCpuTop.sv
// Multicycle core testbench
`timescale 1ns/1ps

module tbCpuTop;
    import rvPkg::*;

    localparam int memWords = 1024;
    localparam int haltLimit = 4000;   // cycles

    logic   clk = 1'b0;
    logic   rstN;
    wordT   memAddr;
    wordT   memWdata;
    wordT   memRdata;
    logic   memRead;
    logic   memWrite;
    logic   halted;

    wordT   mem [memWords];
    wordT   expAddr [$];
    wordT   expData [$];
    wordT   refHaltPc;
    wordT   lastRead;
    wordT   reqAddr;
    wordT   reqWdata;
    logic   reqRead = 1'b0;
    logic   reqWrite = 1'b0;
    integer seed = 32'h205aa80a;
    int     errorCount = 0;
    int     storeCount = 0;
    int     pcIdx;

    always #4 clk = ~clk;

    cpuTop #(.resetPc(32'h0)) dut (
        .clk(clk), .rstN(rstN),
        .memAddr(memAddr), .memRead(memRead), .memWrite(memWrite),
        .memWdata(memWdata), .memRdata(memRdata), .halted(halted)
    );

    // memory model samples requests mid-cycle and answers just after the edge
    always @(negedge clk) begin
        reqRead  = memRead;
        reqWrite = memWrite;
        reqAddr  = memAddr;
        reqWdata = memWdata;
        if (memRead) lastRead = memAddr;
    end

    always @(posedge clk) begin
        #1;
        if (reqWrite) mem[reqAddr[11:2]] = reqWdata;
        if (reqRead) memRdata = mem[reqAddr[11:2]];
    end

    task automatic failRun(input string why);
        errorCount++;
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic checkWord(input string name, input wordT got, input wordT exp);
        if (got !== exp) begin
            failRun($sformatf("mismatch at time %0t: %s got %h expected %h",
                              $time, name, got, exp));
        end
    endtask

    // store stream against the reference
    always @(negedge clk) begin
        if (rstN && memWrite) begin
            if (storeCount >= expAddr.size()) begin
                failRun("the core issued more stores than the reference model");
            end else begin
                checkWord("memAddr", memAddr, expAddr[storeCount]);
                checkWord("memWdata", memWdata, expData[storeCount]);
                storeCount++;
            end
        end
    end

    function automatic wordT encR(int f7, int rs2, int rs1, int f3, int rd);
        return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), opReg};
    endfunction

    function automatic wordT encI(opcodeT op, int imm, int rs1, int f3, int rd);
        return {12'(imm), 5'(rs1), 3'(f3), 5'(rd), op};
    endfunction

    function automatic wordT encS(int imm, int rs2, int rs1);
        logic [11:0] i;
        i = 12'(imm);
        return {i[11:5], 5'(rs2), 5'(rs1), 3'b010, i[4:0], opStore};
    endfunction

    function automatic wordT encB(int off, int f3, int rs1, int rs2);
        logic [12:0] o;
        o = 13'(off);
        return {o[12], o[10:5], 5'(rs2), 5'(rs1), 3'(f3), o[4:1], o[11], opBranch};
    endfunction

    function automatic wordT encU(opcodeT op, int imm, int rd);
        return {20'(imm), 5'(rd), op};
    endfunction

    function automatic wordT encJ(int off, int rd);
        logic [20:0] o;
        o = 21'(off);
        return {o[20], o[10:1], o[11], o[19:12], 5'(rd), opJal};
    endfunction

    task automatic emit(input wordT w);
        mem[pcIdx] = w;
        pcIdx++;
    endtask

    task automatic buildAluMix();
        wordT r;
        int   f3;
        int   alt;
        int   rd;
        for (int k = 1; k < 16; k++) begin
            r = $random(seed);
            emit(encU(opLui, r[31:12], k));
            emit(encI(opImm, r[11:0], k, 0, k));
        end
        // f3 cycles so every operation shows up in both forms
        for (int k = 0; k < 40; k++) begin
            r   = $random(seed);
            f3  = k % 8;
            alt = (k / 16) % 2;
            rd  = (k % 7 == 3) ? 0 : r[3:0];
            if ((k / 8) % 2 == 0) begin
                emit(encR((alt && (f3 == 0 || f3 == 5)) ? 32 : 0, r[8:4], r[12:9], f3, rd));
            end else if (f3 == 1 || f3 == 5) begin
                emit(encI(opImm, {1'b0, alt && f3 == 5, 5'b0, r[17:13]}, r[12:9], f3, rd));
            end else begin
                emit(encI(opImm, r[31:20], r[12:9], f3, rd));
            end
        end
        for (int k = 0; k < 32; k++) emit(encS(32'h400 + 4 * k, k, 0));
    endtask

    task automatic buildLoadStore();
        emit(encU(opLui, 1, 5));                // x5 = 0x1000
        emit(encI(opImm, -2048, 5, 0, 5));      // x5 = 0x800
        emit(encU(opAuipc, 0, 6));
        emit(encI(opImm, 12'h600, 6, 0, 6));
        emit(encU(opAuipc, 20'h12345, 7));
        emit(encU(opLui, 20'hdeadb, 8));
        emit(encI(opImm, -273, 8, 0, 8));
        emit(encS(0, 7, 5));
        emit(encS(4, 8, 5));
        emit(encS(-8, 8, 6));
        emit(encS(12, 7, 6));
        emit(encI(opLoad, 4, 5, 2, 9));
        emit(encI(opLoad, 0, 5, 2, 10));
        emit(encI(opLoad, -8, 6, 2, 11));
        emit(encI(opLoad, 12, 6, 2, 12));
        emit(encI(opLoad, 12'h300, 0, 2, 13));  // untouched fill word
        emit(encI(opLoad, 0, 5, 2, 0));
        emit(encR(0, 10, 9, 0, 14));
        for (int k = 0; k < 16; k++) emit(encS(32 + 4 * k, k, 5));
    endtask

    task automatic buildBranches();
        int f3s [6]  = '{0, 1, 4, 5, 6, 7};
        int takA [6] = '{1, 1, 3, 1, 1, 3};
        int takB [6] = '{2, 4, 1, 3, 3, 1};
        int notA [6] = '{1, 1, 1, 3, 3, 1};
        int notB [6] = '{4, 2, 3, 1, 1, 4};
        int c;
        emit(encI(opImm, 5, 0, 0, 1));
        emit(encI(opImm, 5, 0, 0, 2));
        emit(encI(opImm, -3, 0, 0, 3));
        emit(encI(opImm, 7, 0, 0, 4));
        for (int k = 0; k < 12; k++) begin
            c = k / 2;
            emit(encI(opImm, 100 + k, 0, 0, 20));   // taken marker
            if (k % 2 == 0) emit(encB(8, f3s[c], takA[c], takB[c]));
            else emit(encB(8, f3s[c], notA[c], notB[c]));
            emit(encI(opImm, 200 + k, 0, 0, 20));   // fall-through marker
            emit(encS(12'h600 + 4 * k, 20, 0));
        end
    endtask

    task automatic buildJumps();
        emit(encJ(12, 1));                      // 0 to 12
        emit(encI(opImm, 1, 0, 0, 9));
        emit(encS(12'h700, 9, 0));
        emit(encS(12'h700, 1, 0));              // 12
        emit(encI(opImm, 33, 0, 0, 2));
        emit(encI(opJalr, 0, 2, 0, 3));         // 20 to 32, odd target
        emit(encS(12'h704, 2, 0));
        emit(encI(opImm, 2, 0, 0, 9));
        emit(encS(12'h704, 3, 0));              // 32
        emit(encI(opImm, 47, 0, 0, 5));
        emit(encI(opJalr, 2, 5, 0, 5));         // 40 to 48, rd equals rs1
        emit(encS(12'h70c, 5, 0));
        emit(encS(12'h708, 5, 0));              // 48
        emit(encJ(8, 0));
        emit(encS(12'h710, 1, 0));
    endtask

    task automatic buildProgram(input int id);
        for (int i = 0; i < memWords; i++) begin
            mem[i] = (i * 32'h9e3779b1) ^ 32'hc3a50f1e;
        end
        pcIdx = 0;
        case (id)
            0: buildAluMix();
            1: buildLoadStore();
            2: buildBranches();
            default: buildJumps();
        endcase
        emit(32'h00000073);     // ecall
    endtask

    function automatic wordT aluRef(input int f3, input logic alt, input wordT a, input wordT b);
        case (f3)
            0: return alt ? a - b : a + b;
            1: return a << b[4:0];
            2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3: return (a < b) ? 32'd1 : 32'd0;
            4: return a ^ b;
            5: return alt ? wordT'($signed(a) >>> b[4:0]) : a >> b[4:0];
            6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branchRef(input int f3, input wordT a, input wordT b);
        case (f3)
            0: return a == b;
            1: return a != b;
            4: return $signed(a) < $signed(b);
            5: return $signed(a) >= $signed(b);
            6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    // ISA-level run of the image in mem; fills the expected store stream
    function automatic void refRun();
        wordT    x [32];
        wordT    dm [memWords];
        wordT    pc;
        wordT    nextPc;
        wordT    ins;
        wordT    a;
        wordT    b;
        wordT    iImm;
        wordT    ea;
        regAddrT rd;
        int      f3;
        int      i;
        dm = mem;
        for (i = 0; i < 32; i++) x[i] = '0;
        pc = '0;
        refHaltPc = '1;
        expAddr.delete();
        expData.delete();
        for (i = 0; i < haltLimit; i++) begin
            ins    = dm[pc[11:2]];
            a      = x[ins[19:15]];
            b      = x[ins[24:20]];
            rd     = ins[11:7];
            f3     = ins[14:12];
            iImm   = {{20{ins[31]}}, ins[31:20]};
            ea     = a + ((ins[6:0] == opStore) ? {iImm[31:5], ins[11:7]} : iImm);
            nextPc = pc + 4;
            case (ins[6:0])
                opLui:   x[rd] = {ins[31:12], 12'b0};
                opAuipc: x[rd] = pc + {ins[31:12], 12'b0};
                opJal: begin
                    x[rd]  = pc + 4;
                    nextPc = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
                end
                opJalr: begin
                    x[rd]  = pc + 4;
                    nextPc = (a + iImm) & ~32'd1;
                end
                opBranch: if (branchRef(f3, a, b)) begin
                    nextPc = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                end
                opLoad:  x[rd] = dm[ea[11:2]];
                opStore: begin
                    dm[ea[11:2]] = b;
                    expAddr.push_back(ea);
                    expData.push_back(b);
                end
                opImm:   x[rd] = aluRef(f3, f3 == 5 && ins[30], a, iImm);
                opReg:   x[rd] = aluRef(f3, ins[30], a, b);
                default: begin
                    refHaltPc = pc;     // ecall
                    return;
                end
            endcase
            x[0] = '0;
            pc = nextPc;
        end
    endfunction

    task automatic runProgram();
        int n;
        @(posedge clk);
        #1 rstN = 1'b0;
        storeCount = 0;
        repeat (5) @(posedge clk);
        #1 rstN = 1'b1;
        n = 0;
        while (!memRead && n < 20) begin
            @(negedge clk);
            if (memWrite) failRun("a store was issued before the first fetch");
            n++;
        end
        if (!memRead) failRun("timeout: no fetch after reset release");
        checkWord("first fetch memAddr", memAddr, 32'h0);
        n = 0;
        while (!halted && n < haltLimit) begin
            @(negedge clk);
            n++;
        end
        if (!halted) failRun("timeout: halted never rose");
        checkWord("store count", wordT'(storeCount), wordT'(expAddr.size()));
        checkWord("halt pc", lastRead, refHaltPc);
    endtask

    initial begin
        rstN     = 1'b0;
        memRdata = '0;
        for (int p = 0; p < 4; p++) begin
            buildProgram(p);
            refRun();
            runProgram();
        end
        if (errorCount == 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            failRun("errors were recorded during the run");
        end
    end

endmodule
